// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0 -Wno-fatal
TOP       := regex_scan_tb
FILELIST  := regex_scan_top.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/regex_scan_tb.sv ====
`timescale 1ns/1ps
`include "regex_scan_macros.svh"

module regex_scan_tb
  import regex_scan_pkg::*;
();

  // Idle cycles after eop before the counts are compared
  localparam int SETTLE_CYCLES = 8;
  localparam int CHECK_TIMEOUT = 4;
  localparam int MAX_CYCLES    = 20000;

  logic                   clk;
  logic                   rst_n;
  pkt_beat_t              beat;
  logic                   beat_vld;
  logic                   cfg_we;
  logic [`SCAN_SID_W-1:0] cfg_stream;
  rule_mask_t             cfg_mask;
  scan_count_t            finger_count;
  scan_count_t            root_count;
  logic                   finger_fired;
  logic                   root_fired;

  // Reference model context, prefix length per rule and stream
  int          model_len [2][`SCAN_STREAMS];
  rule_mask_t  model_mask [`SCAN_STREAMS];
  logic [7:0]  pkt_q [$];
  logic [31:0] lfsr_state;

  // Expected DUT results after the current packet
  scan_count_t exp_fcount;
  scan_count_t exp_rcount;
  logic        exp_ffired;
  logic        exp_rfired;

  // Request and acknowledge between stimulus and checker
  int check_req;
  int check_ack;
  int err_count;
  int fault_count;
  int check_total;
  int test_num;
  int test_err_base;

  regex_scan_top i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .beat         (beat),
    .beat_vld     (beat_vld),
    .cfg_we       (cfg_we),
    .cfg_stream   (cfg_stream),
    .cfg_mask     (cfg_mask),
    .finger_count (finger_count),
    .root_count   (root_count),
    .finger_fired (finger_fired),
    .root_fired   (root_fired)
  );

  initial
    clk = 1'b0;

  // 100 ns period
  always #50 clk = ~clk;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic int rand_bits(input int n);
    int v;
    int i;
    v = 0;
    for (i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      v = (v << 1) | int'(lfsr_state[0]);
    end
    return v;
  endfunction

  // Mostly letters of both words, sometimes any byte
  function automatic logic [7:0] payload_byte();
    string letters;
    int    pick;
    letters = "fingerot";
    pick = rand_bits(3);
    if (pick < 6)
    begin
      pick = rand_bits(3);
      return letters[pick];
    end
    pick = rand_bits(8);
    return pick[7:0];
  endfunction

  function automatic string rule_word(input int r);
    if (r == 0)
      return "finger";
    else
      return "root";
  endfunction

  // Longest prefix of word that ends the matched prefix plus c
  function automatic int next_len(input string word, input int len, input logic [7:0] c);
    int   k;
    int   j;
    int   best;
    logic ok;
    best = 0;
    for (k = len + 1; k >= 1; k--)
    begin
      if (best == 0 && k <= word.len() && word[k-1] == c)
      begin
        ok = 1'b1;
        for (j = 0; j < k - 1; j++)
          if (word[j] != word[len - k + 1 + j])
            ok = 1'b0;
        if (ok)
          best = k;
      end
    end
    return best;
  endfunction

  // Scan pkt_q from the saved context, hit if any byte completes the word
  function automatic rule_mask_t ref_scan(input int sid);
    rule_mask_t hits;
    string      word;
    int         r;
    int         i;
    int         len;
    hits = '0;
    for (r = 0; r < 2; r++)
    begin
      word = rule_word(r);
      len  = model_len[r][sid];
      for (i = 0; i < pkt_q.size(); i++)
      begin
        len = next_len(word, len, pkt_q[i]);
        if (len == word.len())
          hits[r] = 1'b1;
      end
      // A disabled rule leaves the saved context alone
      if (model_mask[sid][r])
        model_len[r][sid] = len;
    end
    return hits;
  endfunction

  task automatic predict(input int sid);
    rule_mask_t hits;
    rule_mask_t live;
    hits = ref_scan(sid);
    live = hits & model_mask[sid];
    exp_fcount = exp_fcount + scan_count_t'(live[0]);
    exp_rcount = exp_rcount + scan_count_t'(live[1]);
    exp_ffired = live[0];
    exp_rfired = live[1];
  endtask

  task automatic check_count(input string name, input scan_count_t got,
                             input scan_count_t exp);
    check_total++;
    if (got !== exp)
    begin
      err_count++;
      $display("ERR t=%0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_fired(input string name, input logic got, input logic exp);
    check_total++;
    if (got !== exp)
    begin
      err_count++;
      $display("ERR t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // Comparison process, samples mid-cycle while outputs are stable
  always @(negedge clk)
  begin
    if (check_ack != check_req)
    begin
      check_count("finger_count", finger_count, exp_fcount);
      check_count("root_count", root_count, exp_rcount);
      check_fired("finger_fired", finger_fired, exp_ffired);
      check_fired("root_fired", root_fired, exp_rfired);
      check_ack = check_req;
    end
  end

  // Inputs change 10 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic run_cycles(input int n);
    int waited;
    waited = 0;
    while (waited < n)
    begin
      next_cycle();
      waited++;
    end
  endtask

  task automatic request_check();
    int guard;
    guard = 0;
    check_req++;
    while (check_ack != check_req && guard < CHECK_TIMEOUT)
    begin
      next_cycle();
      guard++;
    end
    if (check_ack != check_req)
    begin
      fault_count++;
      $display("checker did not answer within %0d cycles at %0t", CHECK_TIMEOUT, $time);
    end
  endtask

  task automatic config_write(input int sid, input rule_mask_t mask);
    cfg_we     = 1'b1;
    cfg_stream = sid[`SCAN_SID_W-1:0];
    cfg_mask   = mask;
    model_mask[sid] = mask;
    next_cycle();
    cfg_we = 1'b0;
  endtask

  // Back to back beats, sop on the first and eop on the last
  task automatic send_packet(input int sid);
    int i;
    int n;
    n = pkt_q.size();
    for (i = 0; i < n; i++)
    begin
      beat.data      = pkt_q[i];
      beat.sop       = (i == 0);
      beat.eop       = (i == n - 1);
      beat.stream_id = sid[`SCAN_SID_W-1:0];
      beat_vld       = 1'b1;
      next_cycle();
    end
    beat     = '0;
    beat_vld = 1'b0;
  endtask

  // Idle gap after eop also covers the six cycle rule
  task automatic run_packet(input int sid);
    predict(sid);
    send_packet(sid);
    run_cycles(SETTLE_CYCLES);
    request_check();
  endtask

  task automatic text_packet(input int sid, input string s);
    int i;
    pkt_q.delete();
    for (i = 0; i < s.len(); i++)
      pkt_q.push_back(s[i]);
    run_packet(sid);
  endtask

  task automatic begin_test();
    test_num++;
    test_err_base = err_count + fault_count;
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = err_count + fault_count - test_err_base;
    $display("test %0d %s: %s, %0d mismatches", test_num, name,
             (errs == 0) ? "passed" : "failed", errs);
  endtask

  // Backstop against a stuck run
  initial
  begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < MAX_CYCLES)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("run did not finish within %0d cycles", MAX_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  initial
  begin : stimulus
    int p;
    int sid;
    int plen;
    int i;
    int m;
    rst_n       = 1'b0;
    beat        = '0;
    beat_vld    = 1'b0;
    cfg_we      = 1'b0;
    cfg_stream  = '0;
    cfg_mask    = '0;
    lfsr_state  = 32'hc30333d6;
    exp_fcount  = '0;
    exp_rcount  = '0;
    exp_ffired  = 1'b0;
    exp_rfired  = 1'b0;
    check_req   = 0;
    check_ack   = 0;
    err_count   = 0;
    fault_count = 0;
    check_total = 0;
    test_num    = 0;
    for (i = 0; i < `SCAN_STREAMS; i++)
    begin
      model_mask[i]   = '0;
      model_len[0][i] = 0;
      model_len[1][i] = 0;
    end
    run_cycles(2);
    rst_n = 1'b1;
    next_cycle();

    begin_test();
    request_check();
    end_test("reset values");

    // Word once, then both words twice each
    begin_test();
    config_write(1, 2'b11);
    text_packet(1, "xxfingerxx");
    text_packet(1, "rootfingerrootfinger");
    end_test("single and double rule hits");

    // Split words, with and without a foreign packet in between
    begin_test();
    config_write(2, 2'b11);
    text_packet(2, "abfin");
    text_packet(2, "gerab");
    config_write(3, 2'b11);
    config_write(4, 2'b11);
    text_packet(3, "xxfin");
    text_packet(4, "zzro");
    text_packet(3, "gerxx");
    end_test("split across packets");

    // Partial word left on stream 4, stream 5 opens fresh
    begin_test();
    config_write(5, 2'b11);
    text_packet(4, "zzfin");
    text_packet(5, "gerot");
    end_test("new stream starts clean");

    // Finger off for stream 6, its saved prefix must survive
    begin_test();
    config_write(6, 2'b10);
    text_packet(6, "fingerroot");
    config_write(6, 2'b11);
    text_packet(6, "xfin");
    config_write(6, 2'b10);
    text_packet(6, "zzz");
    config_write(6, 2'b11);
    text_packet(6, "gerx");
    config_write(6, 2'b10);
    text_packet(6, "fin");
    config_write(6, 2'b11);
    text_packet(6, "ger");
    end_test("rule disabled per stream");

    // 40 random packets on streams 8 to 15
    begin_test();
    for (p = 0; p < 40; p++)
    begin
      sid = 8 + rand_bits(3);
      if (rand_bits(1) == 1)
      begin
        m = rand_bits(2);
        config_write(sid, m[1:0]);
      end
      plen = 1 + rand_bits(4);
      pkt_q.delete();
      for (i = 0; i < plen; i++)
        pkt_q.push_back(payload_byte());
      run_packet(sid);
    end
    end_test("random packets");

    $display("summary: %0d tests, %0d checks, %0d mismatches, %0d timeouts",
             test_num, check_total, err_count, fault_count);
    if (err_count == 0 && fault_count == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== include/regex_scan_macros.svh ====
`ifndef REGEX_SCAN_MACROS_SVH
`define REGEX_SCAN_MACROS_SVH

// Payload byte width
`define SCAN_CHAR_W 8

// Stream context table depth and its index width
`define SCAN_STREAMS 64
`define SCAN_SID_W 6

// Match counter width
`define SCAN_COUNT_W 16

// DFA state word, wide enough for the largest rule
`define SCAN_STATE_W 3

// One enable bit per rule
`define SCAN_NUM_RULES 2

// Front end pipeline depths, in register stages from the input beat
`define SCAN_CHAR_DELAY 2
`define SCAN_EOP_DELAY 6

`endif

// ==== regex_scan_top.f ====
+incdir+include
source/regex_scan_pkg.sv
source/dfa_finger.sv
source/dfa_root.sv
source/packet_frontend.sv
source/stream_context_matcher.sv
source/regex_scan_top.sv
dv/regex_scan_tb.sv

// ==== source/dfa_finger.sv ====
`timescale 1ns/1ps
`include "regex_scan_macros.svh"

module dfa_finger
  import regex_scan_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`SCAN_CHAR_W-1:0] char_in,
  input  logic                    char_in_vld,
  input  dfa_state_t              state_in,
  input  logic                    state_in_vld,
  output dfa_state_t              state_out,
  output logic                    accept_out
);

  // One state per matched prefix of "finger"
  // Idle must encode as zero, a new stream restores zero
  typedef enum logic [`SCAN_STATE_W-1:0] {
    F_IDLE,
    F_F,
    F_FI,
    F_FIN,
    F_FING,
    F_FINGE,
    F_FINGER
  } finger_state_e;

  finger_state_e state_q;
  finger_state_e base_state;
  finger_state_e state_d;

  // Next state for one character
  // No proper suffix of the word is also a prefix, so a mismatch
  // only has to look at whether the byte starts a new word
  function automatic finger_state_e step(input finger_state_e cur,
                                         input logic [`SCAN_CHAR_W-1:0] c);
    finger_state_e restart;
    finger_state_e nxt;
    restart = (c == "f") ? F_F : F_IDLE;
    nxt = restart;
    case (cur)
      F_F:
        if (c == "i") nxt = F_FI;
      F_FI:
        if (c == "n") nxt = F_FIN;
      F_FIN:
        if (c == "g") nxt = F_FING;
      F_FING:
        if (c == "e") nxt = F_FINGE;
      F_FINGE:
        if (c == "r") nxt = F_FINGER;
      // Idle and accept both restart on the byte
      default:
        nxt = restart;
    endcase
    return nxt;
  endfunction

  // Loaded state replaces the held one
  // A character in the same cycle steps from the loaded state
  always_comb
  begin
    base_state = state_in_vld ? finger_state_e'(state_in) : state_q;
    state_d    = char_in_vld ? step(base_state, char_in) : base_state;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      state_q <= F_IDLE;
    else
      state_q <= state_d;
  end

  assign state_out  = dfa_state_t'(state_q);
  // High while sitting in the accept state
  assign accept_out = (state_q == F_FINGER);

endmodule

// ==== source/dfa_root.sv ====
`timescale 1ns/1ps
`include "regex_scan_macros.svh"

module dfa_root
  import regex_scan_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`SCAN_CHAR_W-1:0] char_in,
  input  logic                    char_in_vld,
  input  dfa_state_t              state_in,
  input  logic                    state_in_vld,
  output dfa_state_t              state_out,
  output logic                    accept_out
);

  // Matched prefixes of "root", idle at zero
  typedef enum logic [`SCAN_STATE_W-1:0] {
    R_IDLE,
    R_R,
    R_RO,
    R_ROO,
    R_ROOT
  } root_state_e;

  root_state_e state_q;
  root_state_e base_state;
  root_state_e state_d;

  // Only 'r' can start a new prefix, so every mismatch lands in R_R or idle
  // A fourth 'o' after "roo" leaves no prefix standing
  function automatic root_state_e step(input root_state_e cur,
                                       input logic [`SCAN_CHAR_W-1:0] c);
    root_state_e restart;
    root_state_e nxt;
    restart = (c == "r") ? R_R : R_IDLE;
    nxt = restart;
    case (cur)
      R_R:
        if (c == "o") nxt = R_RO;
      R_RO:
        if (c == "o") nxt = R_ROO;
      R_ROO:
        if (c == "t") nxt = R_ROOT;
      default:
        nxt = restart;
    endcase
    return nxt;
  endfunction

  // Load picks the base, a same-cycle character still advances it
  always_comb
  begin
    base_state = state_in_vld ? root_state_e'(state_in) : state_q;
    state_d    = char_in_vld ? step(base_state, char_in) : base_state;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      state_q <= R_IDLE;
    else
      state_q <= state_d;
  end

  assign state_out  = dfa_state_t'(state_q);
  assign accept_out = (state_q == R_ROOT);

endmodule

// ==== source/packet_frontend.sv ====
`timescale 1ns/1ps
`include "regex_scan_macros.svh"

module packet_frontend
  import regex_scan_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  pkt_beat_t               beat,
  input  logic                    beat_vld,
  input  logic                    cfg_we,
  input  logic [`SCAN_SID_W-1:0]  cfg_stream,
  input  rule_mask_t              cfg_mask,
  output scan_ctl_t               ctl,
  output logic [`SCAN_CHAR_W-1:0] char_out,
  output logic                    char_vld
  ,
  output rule_mask_t              rule_enable
);

  // Per-stream rule enables and streams seen since reset
  rule_mask_t               en_table [`SCAN_STREAMS];
  logic [`SCAN_STREAMS-1:0] seen;

  // Character path delay line
  logic [`SCAN_CHAR_W-1:0]     char_pipe [`SCAN_CHAR_DELAY];
  logic [`SCAN_CHAR_DELAY-1:0] vld_pipe;

  // End of packet delay line
  logic [`SCAN_EOP_DELAY-1:0] eop_pipe;

  // Packet start control
  logic                   load_q;
  logic                   new_q;
  logic [`SCAN_SID_W-1:0] sid_q;

  // Config writes land at the next edge
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < `SCAN_STREAMS; i++)
        en_table[i] <= '0;
    end
    else if (cfg_we)
      en_table[cfg_stream] <= cfg_mask;
  end

  // Start of packet, stream id held until the next sop
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      load_q <= 1'b0;
      new_q  <= 1'b0;
      sid_q  <= '0;
    end
    else
    begin
      load_q <= beat_vld & beat.sop;
      if (beat_vld && beat.sop)
      begin
        sid_q <= beat.stream_id;
        new_q <= ~seen[beat.stream_id];
      end
    end
  end

  // Payload bytes carry no reset
  always_ff @(posedge clk)
  begin
    char_pipe[0] <= beat.data;
    for (int i = 1; i < `SCAN_CHAR_DELAY; i++)
      char_pipe[i] <= char_pipe[i-1];
  end

  // Strobes, seen bitmap and enable read
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      vld_pipe    <= '0;
      eop_pipe    <= '0;
      seen        <= '0;
      rule_enable <= '0;
    end
    else
    begin
      vld_pipe <= {vld_pipe[`SCAN_CHAR_DELAY-2:0], beat_vld};
      eop_pipe <= {eop_pipe[`SCAN_EOP_DELAY-2:0], beat_vld & beat.eop};
      // Table read one stage early so enables leave with the eop pulse
      rule_enable <= eop_pipe[`SCAN_EOP_DELAY-2] ? en_table[sid_q] : '0;
      // Stream becomes known once its first packet closes
      if (eop_pipe[`SCAN_EOP_DELAY-1])
        seen[sid_q] <= 1'b1;
    end
  end

  assign char_out = char_pipe[`SCAN_CHAR_DELAY-1];
  assign char_vld = vld_pipe[`SCAN_CHAR_DELAY-1];

  assign ctl = '{
    load_state:    load_q,
    new_stream_id: new_q,
    eop:           eop_pipe[`SCAN_EOP_DELAY-1],
    stream_id:     sid_q
  };

endmodule

// ==== source/regex_scan_pkg.sv ====
`include "regex_scan_macros.svh"

package regex_scan_pkg;

  // Rule chosen by a matcher instance
  // Value doubles as the bit index into rule_mask_t
  typedef enum logic {
    RULE_FINGER = 1'b0,
    RULE_ROOT   = 1'b1
  } rule_sel_e;

  // DFA state word as kept in the per-stream memories
  typedef logic [`SCAN_STATE_W-1:0] dfa_state_t;

  // Match counter
  typedef logic [`SCAN_COUNT_W-1:0] scan_count_t;

  // Bit 0 finger, bit 1 root
  typedef logic [`SCAN_NUM_RULES-1:0] rule_mask_t;

  // One input byte with its packet tags
  typedef struct packed {
    logic [`SCAN_CHAR_W-1:0] data;
    logic                    sop;
    logic                    eop;
    logic [`SCAN_SID_W-1:0]  stream_id;
  } pkt_beat_t;

  // Per-packet control from the front end to the matchers
  typedef struct packed {
    logic                   load_state;
    logic                   new_stream_id;
    logic                   eop;
    logic [`SCAN_SID_W-1:0] stream_id;
  } scan_ctl_t;

endpackage

// ==== source/regex_scan_top.sv ====
`timescale 1ns/1ps
`include "regex_scan_macros.svh"

module regex_scan_top
  import regex_scan_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  pkt_beat_t              beat,
  input  logic                   beat_vld,
  input  logic                   cfg_we,
  input  logic [`SCAN_SID_W-1:0] cfg_stream,
  input  rule_mask_t             cfg_mask,
  output scan_count_t            finger_count,
  output scan_count_t            root_count,
  output logic                   finger_fired,
  output logic                   root_fired
);

  // Shared front end outputs
  scan_ctl_t               ctl;
  logic [`SCAN_CHAR_W-1:0] char_bus;
  logic                    char_vld;
  rule_mask_t              rule_enable;

  packet_frontend i_frontend (
    .clk         (clk),
    .rst_n       (rst_n),
    .beat        (beat),
    .beat_vld    (beat_vld),
    .cfg_we      (cfg_we),
    .cfg_stream  (cfg_stream),
    .cfg_mask    (cfg_mask),
    .ctl         (ctl),
    .char_out    (char_bus),
    .char_vld    (char_vld),
    .rule_enable (rule_enable)
  );

  // One matcher per rule, each picks its own enable bit
  stream_context_matcher #(.RULE(RULE_FINGER)) i_finger_matcher (
    .clk         (clk),
    .rst_n       (rst_n),
    .ctl         (ctl),
    .char_in     (char_bus),
    .char_in_vld (char_vld),
    .enable      (rule_enable[RULE_FINGER]),
    .count       (finger_count),
    .fired       (finger_fired)
  );

  stream_context_matcher #(.RULE(RULE_ROOT)) i_root_matcher (
    .clk         (clk),
    .rst_n       (rst_n),
    .ctl         (ctl),
    .char_in     (char_bus),
    .char_in_vld (char_vld),
    .enable      (rule_enable[RULE_ROOT]),
    .count       (root_count),
    .fired       (root_fired)
  );

endmodule

// ==== source/stream_context_matcher.sv ====
`timescale 1ns/1ps
`include "regex_scan_macros.svh"

module stream_context_matcher
  import regex_scan_pkg::*;
#(
  parameter rule_sel_e RULE = RULE_FINGER
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  scan_ctl_t               ctl,
  input  logic [`SCAN_CHAR_W-1:0] char_in,
  input  logic                    char_in_vld,
  input  logic                    enable,
  output scan_count_t             count,
  output logic                    fired
);

  // Saved DFA state per stream
  dfa_state_t state_mem [`SCAN_STREAMS];

  // State restored at packet start
  // Also kept as the write-back value when the rule is off
  dfa_state_t state_in;
  logic       state_in_vld;

  // DFA input stage
  logic [`SCAN_CHAR_W-1:0] char_in_r;
  logic                    char_in_vld_r;
  dfa_state_t              state_in_r;
  logic                    state_in_vld_r;

  // Raw DFA outputs
  dfa_state_t state_out;
  logic       accept_out;
  // Marks a DFA state that came from a character step
  logic       step_done;

  // DFA output stage
  dfa_state_t state_out_r;
  logic       accept_out_r;

  scan_count_t count_q;
  logic        fired_q;

  // Restore zero for a new stream, else the saved state
  always_ff @(posedge clk)
  begin
    if (ctl.load_state)
      state_in <= ctl.new_stream_id ? '0 : state_mem[ctl.stream_id];
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      state_in_vld <= 1'b0;
    else
      state_in_vld <= ctl.load_state;
  end

  // Register every DFA input and output
  always_ff @(posedge clk)
  begin
    char_in_r   <= char_in;
    state_in_r  <= state_in;
    state_out_r <= state_out;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      char_in_vld_r  <= 1'b0;
      state_in_vld_r <= 1'b0;
      step_done      <= 1'b0;
      accept_out_r   <= 1'b0;
    end
    else
    begin
      char_in_vld_r  <= char_in_vld;
      state_in_vld_r <= state_in_vld;
      step_done      <= char_in_vld_r;
      // Only a fresh step counts as a hit
      // An accept state held across packets would refire otherwise
      accept_out_r   <= accept_out & step_done;
    end
  end

  generate
    if (RULE == RULE_FINGER)
    begin : g_finger
      dfa_finger i_dfa (
        .clk          (clk),
        .rst_n        (rst_n),
        .char_in      (char_in_r),
        .char_in_vld  (char_in_vld_r),
        .state_in     (state_in_r),
        .state_in_vld (state_in_vld_r),
        .state_out    (state_out),
        .accept_out   (accept_out)
      );
    end
    else
    begin : g_root
      dfa_root i_dfa (
        .clk          (clk),
        .rst_n        (rst_n),
        .char_in      (char_in_r),
        .char_in_vld  (char_in_vld_r),
        .state_in     (state_in_r),
        .state_in_vld (state_in_vld_r),
        .state_out    (state_out),
        .accept_out   (accept_out)
      );
    end
  endgenerate

  // Speculative fired flag and count
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      fired_q <= 1'b0;
      count_q <= '0;
    end
    else
    begin
      // Cleared per packet, later hits win
      if (ctl.load_state)
        fired_q <= 1'b0;
      if (accept_out_r)
        fired_q <= 1'b1;
      // At most one count per packet
      if (ctl.eop)
      begin
        if (enable)
          count_q <= count_q + scan_count_t'(fired_q);
        else
          fired_q <= 1'b0;
      end
    end
  end

  // Save context at eop
  // Disabled rule keeps the state from packet start
  always_ff @(posedge clk)
  begin
    if (ctl.eop)
      state_mem[ctl.stream_id] <= enable ? state_out_r : state_in;
  end

  assign count = count_q;
  assign fired = fired_q;

endmodule
